//--- common/rv_defines.svh
// Data width and opcode[6:2] codes for the RV32IM decode/execute slice
// Opcode bits [1:0] are assumed to be 2'b11 and are not decoded
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define RV_XLEN 32

// opcode[6:2]
`define RV_OP_R      5'b01100
`define RV_OP_I      5'b00100
`define RV_OP_LOAD   5'b00000
`define RV_OP_STORE  5'b01000
`define RV_OP_BRANCH 5'b11000
`define RV_OP_JAL    5'b11011
`define RV_OP_JALR   5'b11001
`define RV_OP_LUI    5'b01101
`define RV_OP_AUIPC  5'b00101
`define RV_OP_SYSTEM 5'b11100

`endif

//--- common/rv_pkg.sv
// Shared types for the decode/execute slice
// alu_op_t numbering must stay in step with the ALU case and the controller
`include "rv_defines.svh"

package rv_pkg;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLTU   = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASSB  = 4'd10,
    ALU_MUL    = 4'd11,
    ALU_MULH   = 4'd12,
    ALU_MULHSU = 4'd13,
    ALU_MULHU  = 4'd14
  } alu_op_t;

  // Writeback source select
  localparam logic [1:0] WB_LINK = 2'b00;  // pc + 4
  localparam logic [1:0] WB_ALU  = 2'b01;
  localparam logic [1:0] WB_MEM  = 2'b10;
  localparam logic [1:0] WB_CSR  = 2'b11;

  typedef struct packed {
    logic       a_sel;     // 0 pc, 1 rs1
    logic       b_sel;     // 0 rs2, 1 imm
    logic       reg_wr;
    logic       mem_wr;
    logic       mem_read;
    logic [1:0] wb_sel;
    logic       pc_sel;    // Redirect fetch
    logic       is_mret;
    logic       csr_rd;
    logic       csr_wr;
    alu_op_t    alu_op;
  } ctrl_t;

  // Same word seen as R format (controller) or I format (imm_gen)
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_hi;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_u;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] imm;
  } operands_t;

endpackage

//--- controller/controller.sv
// Control decode plus the ID/EX control register
// Unknown opcodes decode to all controls inactive with ALU_ADD
`timescale 1ns/1ps
`include "rv_defines.svh"

module controller (
  input  logic           clk,
  input  logic           reset,
  input  logic           stall,
  input  logic           flush,
  input  rv_pkg::instr_u instruction,
  input  logic           br_taken,
  output rv_pkg::ctrl_t  ex_ctrl
);
  import rv_pkg::*;

  ctrl_t      ctrl_d;
  logic [2:0] funct3;
  logic       bit25;  // M extension
  logic       bit30;  // SUB / SRA
  logic       bit29;  // mret vs ecall/ebreak

  assign funct3 = instruction.r.funct3;
  assign bit25  = instruction.r.funct7[0];
  assign bit30  = instruction.r.funct7[5];
  assign bit29  = instruction.r.funct7[4];

  always_comb begin
    ctrl_d        = '0;
    ctrl_d.alu_op = ALU_ADD;
    case (instruction.r.opcode[6:2])
      `RV_OP_R: begin
        case ({bit25, bit30, funct3})
          5'b00000: ctrl_d.alu_op = ALU_ADD;
          5'b01000: ctrl_d.alu_op = ALU_SUB;
          5'b00001: ctrl_d.alu_op = ALU_SLL;
          5'b00010: ctrl_d.alu_op = ALU_SLT;
          5'b00011: ctrl_d.alu_op = ALU_SLTU;
          5'b00100: ctrl_d.alu_op = ALU_XOR;
          5'b00101: ctrl_d.alu_op = ALU_SRL;
          5'b01101: ctrl_d.alu_op = ALU_SRA;
          5'b00110: ctrl_d.alu_op = ALU_OR;
          5'b00111: ctrl_d.alu_op = ALU_AND;
          5'b10000: ctrl_d.alu_op = ALU_MUL;
          5'b10001: ctrl_d.alu_op = ALU_MULH;
          5'b10010: ctrl_d.alu_op = ALU_MULHSU;
          5'b10011: ctrl_d.alu_op = ALU_MULHU;
          default:  ctrl_d.alu_op = ALU_ADD;
        endcase
        ctrl_d.a_sel  = 1'b1;
        ctrl_d.wb_sel = WB_ALU;
        ctrl_d.reg_wr = 1'b1;
      end
      `RV_OP_I: begin
        casez ({bit30, funct3})
          4'b?000: ctrl_d.alu_op = ALU_ADD;
          4'b?001: ctrl_d.alu_op = ALU_SLL;
          4'b?010: ctrl_d.alu_op = ALU_SLT;
          4'b?011: ctrl_d.alu_op = ALU_SLTU;
          4'b?100: ctrl_d.alu_op = ALU_XOR;
          4'b0101: ctrl_d.alu_op = ALU_SRL;
          4'b1101: ctrl_d.alu_op = ALU_SRA;
          4'b?110: ctrl_d.alu_op = ALU_OR;
          default: ctrl_d.alu_op = ALU_AND;  // Only ?111 left
        endcase
        ctrl_d.a_sel  = 1'b1;
        ctrl_d.b_sel  = 1'b1;
        ctrl_d.wb_sel = WB_ALU;
        ctrl_d.reg_wr = 1'b1;
      end
      `RV_OP_LOAD: begin
        ctrl_d.a_sel    = 1'b1;
        ctrl_d.b_sel    = 1'b1;
        ctrl_d.mem_read = 1'b1;
        ctrl_d.wb_sel   = WB_MEM;
        ctrl_d.reg_wr   = 1'b1;
      end
      `RV_OP_STORE: begin
        ctrl_d.a_sel  = 1'b1;
        ctrl_d.b_sel  = 1'b1;
        ctrl_d.mem_wr = 1'b1;
      end
      `RV_OP_BRANCH: begin
        ctrl_d.b_sel  = 1'b1;  // Target is pc + imm
        ctrl_d.pc_sel = br_taken;
      end
      `RV_OP_JAL, `RV_OP_JALR: begin
        ctrl_d.a_sel  = (instruction.r.opcode[6:2] == `RV_OP_JALR);
        ctrl_d.b_sel  = 1'b1;
        ctrl_d.wb_sel = WB_LINK;
        ctrl_d.reg_wr = 1'b1;
        ctrl_d.pc_sel = 1'b1;
      end
      `RV_OP_LUI: begin
        ctrl_d.alu_op = ALU_PASSB;
        ctrl_d.b_sel  = 1'b1;
        ctrl_d.wb_sel = WB_ALU;
        ctrl_d.reg_wr = 1'b1;
      end
      `RV_OP_AUIPC: begin
        ctrl_d.b_sel  = 1'b1;
        ctrl_d.wb_sel = WB_ALU;
        ctrl_d.reg_wr = 1'b1;
      end
      `RV_OP_SYSTEM: begin
        ctrl_d.a_sel  = 1'b1;
        ctrl_d.wb_sel = WB_CSR;
        ctrl_d.reg_wr = 1'b1;
        casez ({bit29, funct3})
          4'b1000: ctrl_d.is_mret = 1'b1;
          4'b?001: begin  // csrrw
            ctrl_d.csr_rd = 1'b1;
            ctrl_d.csr_wr = 1'b1;
          end
          default: ;
        endcase
      end
      default: ;  // Stays inactive
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      ex_ctrl <= '0;
    end else if (!stall) begin
      ex_ctrl <= ctrl_d;
    end
  end

endmodule

//--- controller/imm_gen.sv
// Immediate extraction and the ID/EX operand register
// U and J layouts assume RV_XLEN of 32
`timescale 1ns/1ps
`include "rv_defines.svh"

module imm_gen (
  input  logic                clk,
  input  logic                reset,
  input  logic                stall,
  input  logic                flush,
  input  rv_pkg::instr_u      instruction,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output rv_pkg::operands_t   ex_ops
);
  import rv_pkg::*;

  logic [11:0]         imm_hi;
  logic [4:0]          rs1;
  logic [2:0]          funct3;
  logic [4:0]          rd;
  logic [`RV_XLEN-1:0] imm;
  operands_t           ops_d;

  assign imm_hi = instruction.i.imm_hi;
  assign rs1    = instruction.i.rs1;
  assign funct3 = instruction.i.funct3;
  assign rd     = instruction.i.rd;

  always_comb begin
    case (instruction.i.opcode[6:2])
      `RV_OP_LOAD, `RV_OP_I, `RV_OP_JALR, `RV_OP_SYSTEM:
        imm = {{(`RV_XLEN-12){imm_hi[11]}}, imm_hi};
      `RV_OP_STORE:
        imm = {{(`RV_XLEN-12){imm_hi[11]}}, imm_hi[11:5], rd};
      `RV_OP_BRANCH:  // imm[12] is the sign
        imm = {{(`RV_XLEN-12){imm_hi[11]}}, rd[0], imm_hi[10:5], rd[4:1], 1'b0};
      `RV_OP_LUI, `RV_OP_AUIPC:
        imm = {imm_hi, rs1, funct3, 12'b0};
      `RV_OP_JAL:
        imm = {{(`RV_XLEN-20){imm_hi[11]}}, rs1, funct3, imm_hi[0], imm_hi[10:1], 1'b0};
      default: imm = '0;  // R type and unknown
    endcase
  end

  assign ops_d = '{pc: pc, rs1_data: rs1_data, rs2_data: rs2_data, imm: imm};

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      ex_ops <= '0;
    end else if (!stall) begin
      ex_ops <= ops_d;
    end
  end

endmodule

//--- dv/rv_decode_ex_assert.sv
// Pipeline register checks bound to every rv_decode_ex instance
// Stall check assumes flush wins over stall and is off during reset
`timescale 1ns/1ps

module rv_decode_ex_assert (
  input logic          clk,
  input logic          reset,
  input logic          stall,
  input logic          flush,
  input rv_pkg::ctrl_t ex_ctrl
);

  // Reset and flush both clear the control register
  clear_after_reset_or_flush: assert property (
    @(posedge clk) (reset || flush) |=> (ex_ctrl == '0))
    else $error("ex_ctrl not zero one cycle after reset or flush");

  hold_under_stall: assert property (
    @(posedge clk) disable iff (reset) (stall && !flush) |=> $stable(ex_ctrl))
    else $error("ex_ctrl changed while stalled");

  no_load_and_store: assert property (
    @(posedge clk) disable iff (reset) !(ex_ctrl.mem_wr && ex_ctrl.mem_read))
    else $error("mem_wr and mem_read set together");

endmodule

bind rv_decode_ex rv_decode_ex_assert rv_decode_ex_assert_inst (
  .clk     (clk),
  .reset   (reset),
  .stall   (stall),
  .flush   (flush),
  .ex_ctrl (ex_ctrl)
);

//--- dv/rv_decode_ex_golden.txt
// instruction pc rs1_data rs2_data br_taken stall flush ex_ctrl alu_result, all in hex
// ex_ctrl bits: a_sel b_sel reg_wr mem_wr mem_read wb_sel[1:0] pc_sel is_mret csr_rd csr_wr alu_op[3:0]
// R and M types
003100b3 00001000 12345678 11111111 0 0 0 5100 23456789
403100b3 00001004 00000005 00000007 0 0 0 5101 fffffffe
003110b3 00001008 00000001 00000024 0 0 0 5102 00000010
003120b3 0000100c ffffffff 00000001 0 0 0 5103 00000001
003130b3 00001010 ffffffff 00000001 0 0 0 5105 00000000
003140b3 00001014 f0f0f0f0 0ff00ff0 0 0 0 5104 ff00ff00
003150b3 00001018 80000000 00000004 0 0 0 5106 08000000
403150b3 0000101c 80000000 00000004 0 0 0 5107 f8000000
003160b3 00001020 00ff0000 0000ff00 0 0 0 5108 00ffff00
003170b3 00001024 0f0f0f0f 00ff00ff 0 0 0 5109 000f000f
023100b3 00001028 fffffffe 00000003 0 0 0 510b fffffffa
023110b3 0000102c 80000000 80000000 0 0 0 510c 40000000
023120b3 00001030 ffffffff ffffffff 0 0 0 510d ffffffff
023130b3 00001034 ffffffff ffffffff 0 0 0 510e fffffffe
// I types, lui, auipc, load, store
ffd10093 00001038 00000010 00000000 0 0 0 7100 0000000d
40815093 0000103c 80001234 00000000 0 0 0 7107 ff800012
0f017093 00001040 12345678 00000000 0 0 0 7109 00000070
abcde0b7 00001044 00000000 00000000 0 0 0 310a abcde000
00001097 00002048 00000000 00000000 0 0 0 3100 00003048
ff812083 0000104c 00001000 00000000 0 0 0 7600 00000ff8
fe312e23 00001050 00002000 12345678 0 0 0 6800 00001ffc
// Branches, jal, jalr
fe3108e3 00003000 00000000 00000000 1 0 0 2080 00002ff0
00311463 00003004 00000000 00000000 0 0 0 2000 0000300c
fffff0ef 00004000 00000000 00000000 0 0 0 3080 00003ffe
00c100e7 00004004 00005000 00000000 0 0 0 7080 0000500c
// csrrw, mret, unknown opcode
300110f3 00004008 000000aa 00000055 0 0 0 5330 000000ff
30200073 0000400c 00000001 00000002 0 0 0 5340 00000003
0000000b 00006000 00000000 00000010 0 0 0 0000 00006010
// Stall holds, flush clears even under stall
003100b3 00006004 00000100 00000200 0 0 0 5100 00000300
403100b3 00006008 00000005 00000001 0 1 0 5100 00000300
abcde0b7 0000600c 00000000 00000000 0 1 0 5100 00000300
023100b3 00006010 00000003 00000004 0 0 1 0000 00000000
003130b3 00006014 00000007 00000009 0 1 1 0000 00000000
003140b3 00006018 aaaa5555 ffff0000 0 0 0 5104 55555555

//--- dv/rv_decode_ex_tb.sv
// Golden-vector testbench for rv_decode_ex, must run from the project root
// Stops at the first wrong output; one vector per clock cycle
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decode_ex_tb;
  import rv_pkg::*;

  logic                clk;
  logic                reset;
  logic                stall;
  logic                flush;
  instr_u              instruction;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic                br_taken;
  ctrl_t               ex_ctrl;
  logic [`RV_XLEN-1:0] alu_result;

  // One entry per vector line
  logic [`RV_XLEN-1:0] vec_instr[$];
  logic [`RV_XLEN-1:0] vec_pc[$];
  logic [`RV_XLEN-1:0] vec_rs1[$];
  logic [`RV_XLEN-1:0] vec_rs2[$];
  logic                vec_br[$];
  logic                vec_stall[$];
  logic                vec_flush[$];
  ctrl_t               vec_ctrl[$];
  logic [`RV_XLEN-1:0] vec_result[$];
  int                  num_vectors;
  logic                vectors_loaded;

  rv_decode_ex rv_decode_ex_inst (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .flush       (flush),
    .instruction (instruction),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .br_taken    (br_taken),
    .ex_ctrl     (ex_ctrl),
    .alu_result  (alu_result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  task automatic end_with_failure();
    $display("Test failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic load_vectors();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] f_instr;
    logic [31:0] f_pc;
    logic [31:0] f_rs1;
    logic [31:0] f_rs2;
    logic [31:0] f_result;
    logic [3:0]  f_br;
    logic [3:0]  f_stall;
    logic [3:0]  f_flush;
    logic [15:0] f_ctrl;
    fd = $fopen("dv/rv_decode_ex_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open dv/rv_decode_ex_golden.txt from the current directory");
      end_with_failure();
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Blank and comment lines carry no vector
      if (line.len() > 1 && line.getc(0) != "/") begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_instr, f_pc, f_rs1,
                         f_rs2, f_br, f_stall, f_flush, f_ctrl, f_result);
        if (fields != 9) begin
          $display("Golden file line has %0d fields instead of 9: %s", fields, line);
          end_with_failure();
        end
        vec_instr.push_back(f_instr);
        vec_pc.push_back(f_pc);
        vec_rs1.push_back(f_rs1);
        vec_rs2.push_back(f_rs2);
        vec_br.push_back(f_br[0]);
        vec_stall.push_back(f_stall[0]);
        vec_flush.push_back(f_flush[0]);
        vec_ctrl.push_back(f_ctrl[$bits(ctrl_t)-1:0]);
        vec_result.push_back(f_result);
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_vector(input int idx);
    instruction = vec_instr[idx];
    pc          = vec_pc[idx];
    rs1_data    = vec_rs1[idx];
    rs2_data    = vec_rs2[idx];
    br_taken    = vec_br[idx];
    stall       = vec_stall[idx];
    flush       = vec_flush[idx];
  endtask

  task automatic check_outputs(input string where, input ctrl_t exp_ctrl,
                               input logic [`RV_XLEN-1:0] exp_result);
    assert (ex_ctrl === exp_ctrl) else begin
      $display("MISMATCH ex_ctrl %s expected %h actual %h", where, exp_ctrl, ex_ctrl);
      end_with_failure();
    end
    assert (alu_result === exp_result) else begin
      $display("MISMATCH alu_result %s expected %h actual %h", where, exp_result,
               alu_result);
      end_with_failure();
    end
  endtask

  // Watchdog, sized from the vector count once it is known
  initial begin
    wait (vectors_loaded === 1'b1);
    #((num_vectors + 20) * 100);
    $display("Timeout after %0d clock periods, the vectors did not finish", num_vectors + 20);
    end_with_failure();
  end

  initial begin
    reset          = 1'b1;
    stall          = 1'b0;
    flush          = 1'b0;
    instruction    = '0;
    pc             = '0;
    rs1_data       = '0;
    rs2_data       = '0;
    br_taken       = 1'b0;
    vectors_loaded = 1'b0;
    load_vectors();
    num_vectors = vec_instr.size();
    if (num_vectors == 0) begin
      $display("Golden file holds no vectors");
      end_with_failure();
    end
    vectors_loaded = 1'b1;

    repeat (8) @(posedge clk);
    #5 reset = 1'b0;
    check_outputs("after reset", '0, '0);  // Zero controls, ADD of 0 and 0

    for (int i = 0; i < num_vectors; i++) begin
      drive_vector(i);
      @(posedge clk);
      #2;
      check_outputs($sformatf("at vector %0d", i), vec_ctrl[i], vec_result[i]);
      #3;  // Back at 5 ns after the edge
    end

    $display("Test passed");
    $finish;
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the rv_decode_ex testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv_decode_ex_tb \
  -f rv_decode_ex.f > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/Vrv_decode_ex_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

//--- rv_decode_ex.f
+incdir+common
common/rv_pkg.sv
controller/controller.sv
controller/imm_gen.sv
src/alu.sv
src/rv_decode_ex.sv
dv/rv_decode_ex_assert.sv
dv/rv_decode_ex_tb.sv

//--- src/alu.sv
// Execute stage ALU with RV32M multiplies, purely combinational
// Operates on the registered ID/EX controls and operands
`timescale 1ns/1ps
`include "rv_defines.svh"

module alu (
  input  rv_pkg::ctrl_t       ctrl,
  input  rv_pkg::operands_t   ops,
  output logic [`RV_XLEN-1:0] result
);
  import rv_pkg::*;

  localparam int SHW = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0]   op_a;
  logic [`RV_XLEN-1:0]   op_b;
  logic [SHW-1:0]        shamt;
  logic [2*`RV_XLEN-1:0] a_sx, a_zx, b_sx, b_zx;
  logic [2*`RV_XLEN-1:0] prod_ss, prod_su, prod_uu;

  assign op_a  = ctrl.a_sel ? ops.rs1_data : ops.pc;
  assign op_b  = ctrl.b_sel ? ops.imm : ops.rs2_data;
  assign shamt = op_b[SHW-1:0];

  // Widened operands, the low 2*XLEN bits of the product are exact
  assign a_sx = {{`RV_XLEN{op_a[`RV_XLEN-1]}}, op_a};
  assign b_sx = {{`RV_XLEN{op_b[`RV_XLEN-1]}}, op_b};
  assign a_zx = {{`RV_XLEN{1'b0}}, op_a};
  assign b_zx = {{`RV_XLEN{1'b0}}, op_b};

  assign prod_ss = a_sx * b_sx;
  assign prod_su = a_sx * b_zx;
  assign prod_uu = a_zx * b_zx;

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = $signed(op_a) >>> shamt;
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_PASSB:  result = op_b;  // lui
      ALU_MUL:    result = prod_ss[`RV_XLEN-1:0];
      ALU_MULH:   result = prod_ss[2*`RV_XLEN-1:`RV_XLEN];
      ALU_MULHSU: result = prod_su[2*`RV_XLEN-1:`RV_XLEN];
      ALU_MULHU:  result = prod_uu[2*`RV_XLEN-1:`RV_XLEN];
      default:    result = '0;
    endcase
  end

endmodule

//--- src/rv_decode_ex.sv
// Decode/execute slice top, one cycle from instruction to alu_result
// Stall freezes and flush clears both pipeline registers
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decode_ex (
  input  logic                clk,
  input  logic                reset,
  input  logic                stall,
  input  logic                flush,
  input  rv_pkg::instr_u      instruction,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  input  logic                br_taken,
  output rv_pkg::ctrl_t       ex_ctrl,
  output logic [`RV_XLEN-1:0] alu_result
);
  import rv_pkg::*;

  operands_t ex_ops;  // Registered pc, rs1, rs2, imm

  controller controller_inst (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .flush       (flush),
    .instruction (instruction),
    .br_taken    (br_taken),
    .ex_ctrl     (ex_ctrl)
  );

  imm_gen imm_gen_inst (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .flush       (flush),
    .instruction (instruction),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .ex_ops      (ex_ops)
  );

  alu alu_inst (
    .ctrl   (ex_ctrl),
    .ops    (ex_ops),
    .result (alu_result)
  );

endmodule
